/* Makefile */
SIM     := verilator
TOP     := tb_kpd_input
FLIST   := flist.f
OBJ_DIR := obj_dir
FLAGS   := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG     := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+verilog
verilog/kpd_pkg.sv
verilog/keypad_scanner.sv
verilog/key_entry.sv
verilog/store_arbiter.sv
verilog/entry_store.sv
verilog/kpd_input_top.sv
verif/keypad_model.sv
verif/tb_kpd_input.sv

/* verif/keypad_model.sv */
module keypad_model (
    input  logic [3:0]  row,
    input  logic [15:0] pressed,  // one bit per key, index row*4+col
    output logic [3:0]  col
);
    timeunit 1ns;
    timeprecision 100ps;

    // a pressed key shorts its row to its column, columns idle high
    always_comb begin
        col = 4'hf;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (pressed[r*4+c] && !row[r]) begin
                    col[c] = 1'b0;
                end
            end
        end
    end

endmodule

/* verif/tb_kpd_input.sv */
`include "kpd_params.svh"

module tb_kpd_input;
    timeunit 1ns;
    timeprecision 100ps;
    import kpd_pkg::*;

    localparam int SCAN_CYCLES  = 4 * `KPD_SCAN_DIV;
    localparam int HOLD_CYCLES  = (`KPD_DEBOUNCE + 3) * SCAN_CYCLES;  // covers a partial scan
    localparam int PRESS_BUDGET = 80;
    localparam int CYCLE_LIMIT  = PRESS_BUDGET * 2 * HOLD_CYCLES + 2000;

    logic                   clk;
    logic                   rst_n;
    logic [3:0]             row;
    logic [3:0]             col;
    logic [15:0]            pressed;
    logic [`KPD_DATA_W-1:0] sw;
    logic                   input_enable;
    logic                   ignore_pause;
    logic                   host_req;
    logic                   host_ack;
    entry_rec_t             host_rec;
    logic                   host_empty;
    logic [`KPD_DATA_W-1:0] keypad_data;
    logic                   input_complete;
    logic                   switch_enable;
    logic                   cpu_pause;
    logic                   overflow_9th;
    logic                   overflow_10th;

    // reference model of the entry controller
    entry_state_e           m_state;
    entry_state_e           m_saved;
    logic [`KPD_DATA_W-1:0] m_value;
    int                     m_cnt;
    logic                   m_pause;
    logic                   m_swen;
    logic                   m_done;
    entry_rec_t             exp_q[$];  // records the store should hand out, oldest first

    logic [31:0] seed = 32'hc0b1_dfe0;
    int          reads_req = 0;
    int          reads_done = 0;
    int          cycles = 0;

    kpd_input_top i_kpd_input_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .col            (col),
        .sw             (sw),
        .input_enable   (input_enable),
        .ignore_pause   (ignore_pause),
        .host_req       (host_req),
        .row            (row),
        .host_ack       (host_ack),
        .host_rec       (host_rec),
        .host_empty     (host_empty),
        .keypad_data    (keypad_data),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .overflow_9th   (overflow_9th),
        .overflow_10th  (overflow_10th)
    );

    keypad_model i_keypad_model (
        .row     (row),
        .pressed (pressed),
        .col     (col)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic key_code_e digit_key(input int d);
        case (d)
            0:       return KEY_0;
            1:       return KEY_1;
            2:       return KEY_2;
            3:       return KEY_3;
            4:       return KEY_4;
            5:       return KEY_5;
            6:       return KEY_6;
            7:       return KEY_7;
            8:       return KEY_8;
            default: return KEY_9;
        endcase
    endfunction

    function automatic int digit_of(input key_code_e k);
        for (int d = 0; d < 10; d++) begin
            if (digit_key(d) == k) begin
                return d;
            end
        end
        return -1;  // not a digit key
    endfunction

    function automatic void reset_model();
        m_state = ST_BLOCK;
        m_saved = ST_BLOCK;
        m_value = '0;
        m_cnt   = 0;
        m_pause = 1'b0;
        m_swen  = 1'b0;
        m_done  = 1'b0;
    endfunction

    function automatic void enable_model();
        if (m_state == ST_BLOCK) begin
            m_state = ST_KEYPAD;
            m_value = '0;
            m_cnt   = 0;
            m_done  = 1'b0;
            m_swen  = 1'b0;
        end
    endfunction

    // expected effect of one key, given the ignore_pause level at the time
    function automatic void apply_key(input key_code_e k, input logic ign);
        int         d;
        entry_rec_t rec;
        d = digit_of(k);
        if (m_state == ST_PAUSE) begin
            if (k == KEY_PAUSE && !ign) begin
                m_state = m_saved;
                m_pause = 1'b0;
            end
        end else if (k == KEY_PAUSE) begin
            m_saved = m_state;
            m_state = ST_PAUSE;
            m_pause = 1'b1;
        end else if (m_state != ST_BLOCK) begin
            if (k == KEY_SWITCH) begin
                m_swen  = (m_state == ST_KEYPAD);
                m_state = m_swen ? ST_SWITCH : ST_KEYPAD;
            end else if (k == KEY_ENTER) begin
                rec.from_switch = (m_state == ST_SWITCH);
                rec.value       = rec.from_switch ? sw : m_value;
                exp_q.push_back(rec);
                m_state = ST_BLOCK;
                m_done  = 1'b1;
                m_cnt   = 0;
            end else if (m_state == ST_KEYPAD) begin
                if (k == KEY_BKSP && m_cnt > 0) begin
                    m_value = m_value / 10;
                    m_cnt   = m_cnt - 1;
                end else if (d >= 0 && m_cnt < `KPD_MAX_DIGITS) begin
                    m_value = m_value * 10 + d;  // keeps the low KPD_DATA_W bits
                    m_cnt   = m_cnt + 1;
                end
            end
        end
    endfunction

    task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_outputs();
        expect_eq("keypad_data", 64'(keypad_data), 64'(m_value));
        expect_eq("input_complete", 64'(input_complete), 64'(m_done));
        expect_eq("switch_enable", 64'(switch_enable), 64'(m_swen));
        expect_eq("cpu_pause", 64'(cpu_pause), 64'(m_pause));
        expect_eq("overflow_9th", 64'(overflow_9th), 64'(m_cnt >= `KPD_MAX_DIGITS - 1));
        expect_eq("overflow_10th", 64'(overflow_10th), 64'(m_cnt == `KPD_MAX_DIGITS));
    endtask

    task automatic press(input key_code_e k);
        logic [7:0] code;
        int         r;
        int         c;
        code = k;
        r    = 0;
        c    = 0;
        for (int i = 0; i < 4; i++) begin
            if (!code[4+i]) r = i;  // active-low row nibble
            if (!code[i]) c = i;
        end
        @(posedge clk);
        pressed <= 16'b1 << (r * 4 + c);
        repeat (HOLD_CYCLES) @(posedge clk);
        pressed <= '0;
        repeat (HOLD_CYCLES) @(posedge clk);
        apply_key(k, ignore_pause);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic press_random_digits(input int n);
        for (int i = 0; i < n; i++) begin
            press(digit_key(int'((lcg_next() >> 16) % 32'd10)));
        end
    endtask

    task automatic start_entry();
        @(posedge clk);
        input_enable <= 1'b1;
        @(posedge clk);
        input_enable <= 1'b0;
        enable_model();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic set_ignore_pause(input logic v);
        @(posedge clk);
        ignore_pause <= v;
    endtask

    task automatic read_back();
        reads_req++;
        wait (reads_done == reads_req);
    endtask

    // host side, four-phase reads compared against the reference queue
    initial begin : host_checker
        entry_rec_t exp_rec;
        logic       exp_empty;
        host_req <= 1'b0;
        forever begin
            wait (reads_req != reads_done);
            @(negedge clk);
            exp_empty = (exp_q.size() == 0);
            exp_rec   = '0;  // empty store reads as zeros
            if (!exp_empty) begin
                exp_rec = exp_q.pop_front();
            end
            expect_eq("host_empty", 64'(host_empty), 64'(exp_empty));
            @(posedge clk);
            host_req <= 1'b1;
            @(negedge clk);
            while (!host_ack) @(negedge clk);
            expect_eq("host_rec", 64'(host_rec), 64'(exp_rec));
            @(posedge clk);
            host_req <= 1'b0;
            @(negedge clk);
            while (host_ack) @(negedge clk);
            reads_done++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int n;
        rst_n        <= 1'b0;
        pressed      <= '0;
        sw           <= '0;
        input_enable <= 1'b0;
        ignore_pause <= 1'b0;
        reset_model();
        repeat (7) @(posedge clk);
        @(negedge clk);
        expect_eq("row", 64'(row), 64'(4'hf));  // no row driven in reset
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs();
        expect_eq("host_empty", 64'(host_empty), 64'(1));
        expect_eq("host_ack", 64'(host_ack), 64'(0));

        // random length entry, then ten digits that may wrap
        start_entry();
        n = 1 + int'((lcg_next() >> 16) % 32'd10);
        press_random_digits(n);
        press(KEY_ENTER);
        read_back();
        start_entry();
        press_random_digits(10);
        press(KEY_ENTER);
        read_back();

        start_entry();
        press(KEY_BKSP);           // nothing to remove yet
        press_random_digits(11);   // eleventh digit dropped
        press(KEY_BKSP);
        press(KEY_ENTER);
        read_back();

        // switch source, then back to keypad digits
        @(posedge clk);
        sw <= lcg_next();
        start_entry();
        press_random_digits(2);
        press(KEY_SWITCH);
        press(KEY_ENTER);
        read_back();
        start_entry();
        press_random_digits(1);
        press(KEY_SWITCH);
        press(KEY_SWITCH);
        press_random_digits(2);
        press(KEY_ENTER);
        read_back();

        start_entry();
        press_random_digits(2);
        press(KEY_PAUSE);
        press_random_digits(1);    // ignored while paused
        set_ignore_pause(1'b1);
        press(KEY_PAUSE);
        set_ignore_pause(1'b0);
        press(KEY_PAUSE);
        press_random_digits(1);
        press(KEY_ENTER);
        read_back();

        // fifth record has to wait for room in the store
        for (int e = 0; e < 5; e++) begin
            start_entry();
            press_random_digits(2);
            press(KEY_ENTER);
        end
        expect_eq("wr_req", 64'(i_kpd_input_top.wr_req), 64'(1));
        expect_eq("host_empty", 64'(host_empty), 64'(0));
        for (int e = 0; e < 6; e++) begin
            read_back();
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verilog/entry_store.sv */
`include "kpd_params.svh"

module entry_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  kpd_pkg::entry_rec_t push_rec,
    input  logic                pop,
    output kpd_pkg::entry_rec_t rd_rec,
    output logic                empty,
    output logic                full
);
    import kpd_pkg::*;

    localparam int DEPTH = `KPD_STORE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_rec_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;  // wraps for any depth
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign rd_rec  = empty ? '0 : mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_rec;
    end

endmodule

/* verilog/key_entry.sv */
`include "kpd_params.svh"

module key_entry (
    input  logic                   clk,
    input  logic                   rst_n,
    input  kpd_pkg::key_code_e     key_code,
    input  logic                   input_enable,
    input  logic                   ignore_pause,
    input  logic [`KPD_DATA_W-1:0] sw,
    input  logic                   wr_ack,
    output logic [`KPD_DATA_W-1:0] keypad_data,
    output logic                   input_complete,
    output logic                   switch_enable,
    output logic                   cpu_pause,
    output logic                   overflow_9th,
    output logic                   overflow_10th,
    output logic                   wr_req,
    output kpd_pkg::entry_rec_t    wr_rec
);
    import kpd_pkg::*;

    localparam int DW    = `KPD_DATA_W;
    localparam int CNT_W = $clog2(`KPD_MAX_DIGITS + 1);

    entry_state_e     state;
    entry_state_e     saved_state;   // where pause returns to
    logic [CNT_W-1:0] digit_cnt;
    logic             is_digit;
    logic [3:0]       digit_val;
    logic             entering;      // editing, either source
    logic             enter_hit;
    logic             wr_busy;

    assign overflow_9th  = (digit_cnt >= CNT_W'(`KPD_MAX_DIGITS - 1));
    assign overflow_10th = (digit_cnt == CNT_W'(`KPD_MAX_DIGITS));
    assign entering      = (state == ST_SWITCH) || (state == ST_KEYPAD);
    assign enter_hit     = entering && (key_code == KEY_ENTER);
    assign wr_busy       = wr_req | wr_ack;  // write handshake not yet closed

    always_comb begin
        is_digit = 1'b1;
        case (key_code)
            KEY_0:   digit_val = 4'd0;
            KEY_1:   digit_val = 4'd1;
            KEY_2:   digit_val = 4'd2;
            KEY_3:   digit_val = 4'd3;
            KEY_4:   digit_val = 4'd4;
            KEY_5:   digit_val = 4'd5;
            KEY_6:   digit_val = 4'd6;
            KEY_7:   digit_val = 4'd7;
            KEY_8:   digit_val = 4'd8;
            KEY_9:   digit_val = 4'd9;
            default: begin
                digit_val = 4'd0;
                is_digit  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_BLOCK;
            saved_state    <= ST_BLOCK;
            keypad_data    <= '0;
            digit_cnt      <= '0;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
        end else if (state == ST_PAUSE) begin
            if (key_code == KEY_PAUSE && !ignore_pause) begin
                state     <= saved_state;
                cpu_pause <= 1'b0;
            end
        end else if (key_code == KEY_PAUSE) begin
            saved_state <= state;  // pause from any other state
            state       <= ST_PAUSE;
            cpu_pause   <= 1'b1;
        end else if (state == ST_BLOCK) begin
            if (input_enable && !wr_busy) begin
                state          <= ST_KEYPAD;
                input_complete <= 1'b0;
                switch_enable  <= 1'b0;
                keypad_data    <= '0;
                digit_cnt      <= '0;
            end
        end else begin
            case (key_code)
                KEY_SWITCH: begin
                    state         <= (state == ST_SWITCH) ? ST_KEYPAD : ST_SWITCH;
                    switch_enable <= (state == ST_KEYPAD);
                end
                KEY_ENTER: begin
                    state          <= ST_BLOCK;
                    input_complete <= 1'b1;
                    digit_cnt      <= '0;
                end
                KEY_BKSP: begin
                    if (state == ST_KEYPAD && digit_cnt != '0) begin
                        keypad_data <= keypad_data / DW'(10);
                        digit_cnt   <= digit_cnt - 1'b1;
                    end
                end
                default: begin
                    if (state == ST_KEYPAD && is_digit &&
                        digit_cnt < CNT_W'(`KPD_MAX_DIGITS)) begin
                        keypad_data <= keypad_data * DW'(10) + DW'(digit_val);  // wraps mod 2^DW
                        digit_cnt   <= digit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // four-phase writer, req drops once ack is seen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_req <= 1'b0;
        end else if (wr_ack) begin
            wr_req <= 1'b0;
        end else if (enter_hit) begin
            wr_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (enter_hit) begin
            wr_rec.from_switch <= (state == ST_SWITCH);
            wr_rec.value       <= (state == ST_SWITCH) ? sw : keypad_data;
        end
    end

endmodule

/* verilog/keypad_scanner.sv */
`include "kpd_params.svh"

module keypad_scanner (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [3:0]         col,
    output logic [3:0]         row,
    output kpd_pkg::key_code_e key_code
);
    import kpd_pkg::*;

    localparam int DIV_W = $clog2(`KPD_SCAN_DIV + 1);
    localparam int DEB_W = $clog2(`KPD_DEBOUNCE + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       row_idx;
    logic [11:0]      scan_buf;     // rows 0..2 of the scan in progress
    logic [15:0]      scan_now;     // one bit per pressed key
    logic [15:0]      scan_last;
    logic [DEB_W-1:0] stable_cnt;
    logic [DEB_W-1:0] stable_nxt;
    logic             slot_end;
    logic             scan_end;
    logic             reported;     // held until a debounced release
    logic             scan_on;      // rows stay released until scanning starts
    logic [3:0]       key_idx;
    logic [7:0]       key_pat;

    assign row      = scan_on ? ~(4'b0001 << row_idx) : 4'hf;
    assign slot_end = (div_cnt == DIV_W'(`KPD_SCAN_DIV - 1));
    assign scan_end = slot_end && (row_idx == 2'd3);
    assign scan_now = {~col, scan_buf};  // valid while the last row is sampled
    assign key_pat  = {~(4'b0001 << key_idx[3:2]), ~(4'b0001 << key_idx[1:0])};

    always_comb begin
        key_idx = '0;
        for (int i = 0; i < 16; i++) begin
            if (scan_now[i]) begin
                key_idx = 4'(i);
            end
        end
    end

    // count of consecutive identical snapshots, saturating
    always_comb begin
        if (scan_now != scan_last) begin
            stable_nxt = DEB_W'(1);
        end else if (stable_cnt == DEB_W'(`KPD_DEBOUNCE)) begin
            stable_nxt = stable_cnt;
        end else begin
            stable_nxt = stable_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            row_idx    <= '0;
            scan_buf   <= '0;
            scan_last  <= '0;
            stable_cnt <= '0;
            reported   <= 1'b0;
            scan_on    <= 1'b0;
            key_code   <= KEY_NONE;
        end else begin
            key_code <= KEY_NONE;  // one-cycle pulse
            scan_on  <= 1'b1;
            div_cnt  <= slot_end ? '0 : div_cnt + 1'b1;
            if (slot_end) begin
                row_idx <= row_idx + 1'b1;
                if (!scan_end) begin
                    scan_buf[row_idx*4 +: 4] <= ~col;
                end
            end
            if (scan_end) begin
                scan_last  <= scan_now;
                stable_cnt <= stable_nxt;
                if (stable_nxt == DEB_W'(`KPD_DEBOUNCE)) begin
                    if (scan_now == '0) begin
                        reported <= 1'b0;
                    end else if ($onehot(scan_now) && !reported) begin
                        key_code <= key_code_e'(key_pat);
                        reported <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* verilog/kpd_input_top.sv */
`include "kpd_params.svh"

module kpd_input_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [3:0]             col,
    input  logic [`KPD_DATA_W-1:0] sw,
    input  logic                   input_enable,
    input  logic                   ignore_pause,
    input  logic                   host_req,
    output logic [3:0]             row,
    output logic                   host_ack,
    output kpd_pkg::entry_rec_t    host_rec,
    output logic                   host_empty,
    output logic [`KPD_DATA_W-1:0] keypad_data,
    output logic                   input_complete,
    output logic                   switch_enable,
    output logic                   cpu_pause,
    output logic                   overflow_9th,
    output logic                   overflow_10th
);
    import kpd_pkg::*;

    key_code_e  key_code;
    logic       wr_req;
    logic       wr_ack;
    entry_rec_t wr_rec;
    logic       push;
    logic       pop;
    logic       full;
    entry_rec_t push_rec;
    entry_rec_t rd_rec;

    keypad_scanner i_keypad_scanner (
        .clk      (clk),
        .rst_n    (rst_n),
        .col      (col),
        .row      (row),
        .key_code (key_code)
    );

    key_entry i_key_entry (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_code       (key_code),
        .input_enable   (input_enable),
        .ignore_pause   (ignore_pause),
        .sw             (sw),
        .wr_ack         (wr_ack),
        .keypad_data    (keypad_data),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .overflow_9th   (overflow_9th),
        .overflow_10th  (overflow_10th),
        .wr_req         (wr_req),
        .wr_rec         (wr_rec)
    );

    store_arbiter i_store_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_rec   (wr_rec),
        .host_req (host_req),
        .full     (full),
        .rd_rec   (rd_rec),
        .wr_ack   (wr_ack),
        .host_ack (host_ack),
        .host_rec (host_rec),
        .push     (push),
        .push_rec (push_rec),
        .pop      (pop)
    );

    entry_store i_entry_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_rec (push_rec),
        .pop      (pop),
        .rd_rec   (rd_rec),
        .empty    (host_empty),
        .full     (full)
    );

endmodule

/* verilog/kpd_params.svh */
`ifndef KPD_PARAMS_SVH
`define KPD_PARAMS_SVH

// width of an entered value and of the stored record payload
`define KPD_DATA_W      32
// longest decimal entry
`define KPD_MAX_DIGITS  10
// clock cycles each row stays driven
`define KPD_SCAN_DIV    4
// full scans a key pattern must hold before it counts
`define KPD_DEBOUNCE    2
// entry records held for the host
`define KPD_STORE_DEPTH 4

`endif

/* verilog/kpd_pkg.sv */
`include "kpd_params.svh"

package kpd_pkg;

    // {row, col} patterns as seen on the matrix, both nibbles active low
    typedef enum logic [7:0] {
        KEY_NONE   = 8'h00,
        KEY_0      = 8'b0111_1101,
        KEY_1      = 8'b1110_1110,
        KEY_2      = 8'b1110_1101,
        KEY_3      = 8'b1110_1011,
        KEY_4      = 8'b1101_1110,
        KEY_5      = 8'b1101_1101,
        KEY_6      = 8'b1101_1011,
        KEY_7      = 8'b1011_1110,
        KEY_8      = 8'b1011_1101,
        KEY_9      = 8'b1011_1011,
        KEY_BKSP   = 8'b0111_1110,  // "*"
        KEY_ENTER  = 8'b0111_1011,  // "#"
        KEY_PAUSE  = 8'b1110_0111,  // "A"
        KEY_SWITCH = 8'b1101_0111,  // "B"
        KEY_C      = 8'b1011_0111,
        KEY_D      = 8'b0111_0111
    } key_code_e;

    typedef enum logic [1:0] {
        ST_BLOCK  = 2'b00,
        ST_SWITCH = 2'b01,
        ST_KEYPAD = 2'b10,
        ST_PAUSE  = 2'b11
    } entry_state_e;

    typedef struct packed {
        logic                   from_switch;
        logic [`KPD_DATA_W-1:0] value;
    } entry_rec_t;

endpackage

/* verilog/store_arbiter.sv */
module store_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_req,
    input  kpd_pkg::entry_rec_t wr_rec,
    input  logic                host_req,
    input  logic                full,
    input  kpd_pkg::entry_rec_t rd_rec,
    output logic                wr_ack,
    output logic                host_ack,
    output kpd_pkg::entry_rec_t host_rec,
    output logic                push,
    output kpd_pkg::entry_rec_t push_rec,
    output logic                pop
);
    typedef enum logic [1:0] {ARB_IDLE, ARB_STROBE, ARB_ACK} arb_phase_e;

    arb_phase_e phase;
    logic       grant_host;  // owner of the current transfer
    logic       prio_host;   // host wins the next tie
    logic       wr_elig;
    logic       host_elig;
    logic       pick_host;

    assign wr_elig   = wr_req & ~wr_ack & ~full;  // full store holds the writer off
    assign host_elig = host_req & ~host_ack;
    assign pick_host = host_elig & (~wr_elig | prio_host);
    assign push_rec  = wr_rec;                    // writer keeps it stable under req

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= ARB_IDLE;
            grant_host <= 1'b0;
            prio_host  <= 1'b0;
            push       <= 1'b0;
            pop        <= 1'b0;
            wr_ack     <= 1'b0;
            host_ack   <= 1'b0;
        end else begin
            push <= 1'b0;
            pop  <= 1'b0;
            case (phase)
                ARB_IDLE: begin
                    if (wr_elig || host_elig) begin
                        grant_host <= pick_host;
                        prio_host  <= ~pick_host;
                        push       <= ~pick_host;
                        pop        <= pick_host;
                        phase      <= ARB_STROBE;
                    end
                end
                ARB_STROBE: begin
                    // store acts on this edge, so ack follows it
                    wr_ack   <= ~grant_host;
                    host_ack <= grant_host;
                    phase    <= ARB_ACK;
                end
                default: begin
                    if (grant_host ? !host_req : !wr_req) begin
                        wr_ack   <= 1'b0;
                        host_ack <= 1'b0;
                        phase    <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    // oldest record before the pop, zeros when the store was empty
    always_ff @(posedge clk) begin
        if (phase == ARB_STROBE && grant_host) begin
            host_rec <= rd_rec;
        end
    end

endmodule
